// File: hdl/zx_pager_pkg.sv
// Shared widths, machine types and flat memory layout for the ZX Spectrum pager.
// Referenced by scoped names from the RTL and the testbench.

package zx_pager_pkg;

	// =========================================================================
	// Bus widths
	// =========================================================================
	localparam int unsigned cpu_adr_w = 16;  // Z80 address space
	localparam int unsigned data_w    = 8;   // Byte wide data
	localparam int unsigned ram_adr_w = 18;  // 256K flat RAM
	localparam int unsigned seg_w     = 14;  // 16K segment offset

	// =========================================================================
	// Machine type, sampled once per reset
	// =========================================================================
	typedef enum logic [1:0] {
		m_zx48,   // Fixed 48K layout, no paging
		m_zx128,  // 128K / +2 with port 7FFD
		m_plus3   // +2A / +3 with ports 7FFD and 1FFD
	} machine_e;

	// =========================================================================
	// Flat memory layout
	// =========================================================================
	// RAM bank b sits at b * 16K, so the eight banks fill the lower 128K
	localparam logic [ram_adr_w-1:0] rom_base = 18'h20000;  // ROM 0 image
	localparam int unsigned          rom_count = 4;         // 16K each after rom_base

	// Data seen by the CPU on any port read
	localparam logic [data_w-1:0] io_fill = 8'hFF;

endpackage

// File: hdl/cpu_req_if.sv
// One decoded CPU cycle, passed from the Wishbone slave to the pager core.
// valid holds with stable fields until the one cycle done pulse.

interface cpu_req_if;

	logic                               valid;
	logic                               io;    // Port cycle rather than memory
	logic                               we;
	logic [zx_pager_pkg::cpu_adr_w-1:0] adr;
	logic [zx_pager_pkg::data_w-1:0]    wdat;
	logic                               done;  // One cycle completion
	logic [zx_pager_pkg::data_w-1:0]    rdat;  // Valid with done

	modport requester (output valid, io, we, adr, wdat, input done, rdat);
	modport responder (input valid, io, we, adr, wdat, output done, rdat);

endinterface

// File: hdl/ram_req_if.sv
// One mapped RAM cycle, passed from the pager core to the Wishbone master.
// Same handshake as the CPU side, with a flat RAM address.

interface ram_req_if;

	logic                               valid;
	logic                               we;
	logic [zx_pager_pkg::ram_adr_w-1:0] adr;   // Flat address
	logic [zx_pager_pkg::data_w-1:0]    wdat;
	logic                               done;
	logic [zx_pager_pkg::data_w-1:0]    rdat;

	// The pager core requests, the RAM master answers
	modport requester (output valid, we, adr, wdat, input done, rdat);
	modport responder (input valid, we, adr, wdat, output done, rdat);

endinterface

// File: hdl/wb_cpu_slave.sv
// Wishbone classic slave on the CPU side. Captures one cycle at a time,
// holds it on the request interface and returns data with a single ack.

module wb_cpu_slave (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               cpu_cyc,
	input  logic                               cpu_stb,
	input  logic                               cpu_we,
	input  logic                               cpu_io,
	input  logic [zx_pager_pkg::cpu_adr_w-1:0] cpu_adr,
	input  logic [zx_pager_pkg::data_w-1:0]    cpu_dat_w,
	output logic [zx_pager_pkg::data_w-1:0]    cpu_dat_r,
	output logic                               cpu_ack,
	cpu_req_if.requester                       req
);

	logic accept;

	// New strobe only counts once the previous ack has been seen
	assign accept = cpu_cyc && cpu_stb && !req.valid && !cpu_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req.valid <= 1'b0;
			cpu_ack   <= 1'b0;
		end else begin
			cpu_ack <= 1'b0;  // Single cycle ack
			if (req.done) begin
				req.valid <= 1'b0;
				cpu_ack   <= 1'b1;
			end else if (accept) begin
				req.valid <= 1'b1;
			end
		end
	end

	// Cycle fields and read data
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			req.io   <= cpu_io;
			req.we   <= cpu_we;
			req.adr  <= cpu_adr;
			req.wdat <= cpu_dat_w;
		end
		if (req.done) begin
			cpu_dat_r <= req.rdat;
		end
	end

	// Master keeps its strobe up until it has taken the ack
	ack_inside_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_ack |-> cpu_stb);

	// Core only finishes a request that is still held
	valid_held_to_done: assert property (@(posedge clk_sys) disable iff (reset)
		req.done |-> req.valid);

endmodule

// File: hdl/page_latch.sv
// Paging registers for ports 7FFD and 1FFD with the lock bit.
// The machine type is latched into mode while reset is high.

module page_latch (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  zx_pager_pkg::machine_e             machine,
	input  logic                               io_write,  // Pulse per completed port write
	input  logic [zx_pager_pkg::cpu_adr_w-1:0] adr,
	input  logic [zx_pager_pkg::data_w-1:0]    wdat,
	output zx_pager_pkg::machine_e             mode,
	output logic [zx_pager_pkg::data_w-1:0]    page_7ffd,
	output logic [zx_pager_pkg::data_w-1:0]    page_1ffd
);

	logic is_plus3;
	logic paging_off;
	logic hit_7ffd;
	logic hit_1ffd;

	assign is_plus3   = (mode == zx_pager_pkg::m_plus3);
	assign paging_off = (mode == zx_pager_pkg::m_zx48) || page_7ffd[5];  // Bit 5 locks

	// =========================================================================
	// Port decode
	// =========================================================================
	// 7FFD is partially decoded, the +3 also needs A14 to keep 1FFD apart
	assign hit_7ffd = !paging_off && !adr[15] && !adr[1] && (adr[14] || !is_plus3);

	// 1FFD only exists on the +3
	assign hit_1ffd = is_plus3 && !paging_off && (adr[15:12] == 4'h1) && !adr[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mode      <= machine;  // Sampled machine type
			page_7ffd <= '0;
			page_1ffd <= '0;
		end else if (io_write) begin
			if (hit_7ffd) begin
				page_7ffd <= wdat;
			end else if (hit_1ffd) begin
				page_1ffd <= wdat;
			end
		end
	end

endmodule

// File: hdl/bank_mapper.sv
// Maps a CPU address to the flat RAM address from the paging registers
// and flags writes that land on a ROM segment.

module bank_mapper (
	input  zx_pager_pkg::machine_e             mode,
	input  logic [zx_pager_pkg::data_w-1:0]    page_7ffd,
	input  logic [zx_pager_pkg::data_w-1:0]    page_1ffd,
	input  logic [zx_pager_pkg::cpu_adr_w-1:0] adr,
	input  logic                               we,
	output logic [zx_pager_pkg::ram_adr_w-1:0] ram_adr,
	output logic                               blocked
);

	logic [1:0]                                  seg;
	logic [zx_pager_pkg::seg_w-1:0]              offset;
	logic                                        special;
	logic                                        is_rom;
	logic [2:0]                                  bank;
	logic [3:0][2:0]                             special_banks;  // Index by segment
	logic [$clog2(zx_pager_pkg::rom_count)-1:0]  rom_idx;
	logic [zx_pager_pkg::ram_adr_w-1:0]          rom_off;
	logic [zx_pager_pkg::ram_adr_w-1:0]          bank_adr;

	assign seg     = adr[15:14];
	assign offset  = adr[zx_pager_pkg::seg_w-1:0];
	assign special = (mode == zx_pager_pkg::m_plus3) && page_1ffd[0];

	// +3 all RAM layouts, segment 0 rightmost
	always_comb begin
		case (page_1ffd[2:1])
			2'b00:   special_banks = {3'd3, 3'd2, 3'd1, 3'd0};
			2'b01:   special_banks = {3'd7, 3'd6, 3'd5, 3'd4};
			2'b10:   special_banks = {3'd3, 3'd6, 3'd5, 3'd4};
			default: special_banks = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
	end

	always_comb begin
		case (mode)
			zx_pager_pkg::m_zx48:  rom_idx = 2'd1;                      // 48K BASIC
			zx_pager_pkg::m_plus3: rom_idx = {page_1ffd[2], page_7ffd[4]};
			default:               rom_idx = {1'b0, page_7ffd[4]};
		endcase
	end

	always_comb begin
		is_rom = 1'b0;
		bank   = 3'd0;
		if (special) begin
			bank = special_banks[seg];
		end else begin
			case (seg)
				2'd0:    is_rom = 1'b1;
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				default: bank = (mode == zx_pager_pkg::m_zx48) ? 3'd0 : page_7ffd[2:0];
			endcase
		end
	end

	assign rom_off  = {{(zx_pager_pkg::ram_adr_w - zx_pager_pkg::seg_w - $bits(rom_idx)){1'b0}},
		rom_idx, offset};
	assign bank_adr = {{(zx_pager_pkg::ram_adr_w - zx_pager_pkg::seg_w - 3){1'b0}}, bank, offset};

	assign ram_adr = is_rom ? zx_pager_pkg::rom_base + rom_off : bank_adr;
	assign blocked = we && is_rom;  // ROM is read only

endmodule

// File: hdl/pager_core.sv
// Pager core. Port cycles go to the paging registers and finish here,
// memory cycles are mapped and forwarded to RAM unless they write ROM.

module pager_core (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_pager_pkg::machine_e machine,
	cpu_req_if.responder           req,
	ram_req_if.requester           ram
);

	zx_pager_pkg::machine_e             mode;
	logic [zx_pager_pkg::data_w-1:0]    page_7ffd;
	logic [zx_pager_pkg::data_w-1:0]    page_1ffd;
	logic [zx_pager_pkg::ram_adr_w-1:0] map_adr;
	logic                               blocked;
	logic                               io_write;
	logic                               start;
	logic                               local_done;

	page_latch page_latch_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.machine   (machine),
		.io_write  (io_write),
		.adr       (req.adr),
		.wdat      (req.wdat),
		.mode      (mode),
		.page_7ffd (page_7ffd),
		.page_1ffd (page_1ffd)
	);

	bank_mapper bank_mapper_inst (
		.mode      (mode),
		.page_7ffd (page_7ffd),
		.page_1ffd (page_1ffd),
		.adr       (req.adr),
		.we        (req.we),
		.ram_adr   (map_adr),
		.blocked   (blocked)
	);

	// =========================================================================
	// Cycle routing
	// =========================================================================
	assign start      = req.valid && !req.done && !ram.valid;  // Fresh request
	assign local_done = req.io || blocked;                     // No RAM access needed

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req.done  <= 1'b0;
			ram.valid <= 1'b0;
			io_write  <= 1'b0;
		end else begin
			req.done <= 1'b0;
			io_write <= 1'b0;
			if (ram.done) begin
				ram.valid <= 1'b0;
				req.done  <= 1'b1;
			end else if (start) begin
				if (local_done) begin
					req.done <= 1'b1;
					io_write <= req.io && req.we;  // Registers update with done
				end else begin
					ram.valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start) begin
			ram.we   <= req.we;
			ram.adr  <= map_adr;
			ram.wdat <= req.wdat;
		end
		if (ram.done) begin
			req.rdat <= ram.rdat;
		end else if (start) begin
			req.rdat <= zx_pager_pkg::io_fill;  // Port reads float high
		end
	end

	// No write ever reaches the ROM images
	rom_never_written: assert property (@(posedge clk_sys) disable iff (reset)
		ram.valid && ram.we |-> ram.adr < zx_pager_pkg::rom_base);

endmodule

// File: hdl/ram_master.sv
// Wishbone classic master on the RAM side. Runs one bus cycle per
// mapped request and hands back the read data with done.

module ram_master (
	input  logic                               clk_sys,
	input  logic                               reset,
	ram_req_if.responder                       ram,
	output logic                               ram_cyc,
	output logic                               ram_stb,
	output logic                               ram_we,
	output logic [zx_pager_pkg::ram_adr_w-1:0] ram_adr,
	output logic [zx_pager_pkg::data_w-1:0]    ram_dat_w,
	input  logic [zx_pager_pkg::data_w-1:0]    ram_dat_r,
	input  logic                               ram_ack
);

	logic launch;
	logic finish;

	assign launch = ram.valid && !ram_cyc && !ram.done;
	assign finish = ram_stb && ram_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_cyc  <= 1'b0;
			ram_stb  <= 1'b0;
			ram_we   <= 1'b0;
			ram.done <= 1'b0;
		end else begin
			ram.done <= 1'b0;
			if (finish) begin
				ram_cyc  <= 1'b0;  // Bus released with done
				ram_stb  <= 1'b0;
				ram_we   <= 1'b0;
				ram.done <= 1'b1;
			end else if (launch) begin
				ram_cyc <= 1'b1;
				ram_stb <= 1'b1;
				ram_we  <= ram.we;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (launch) begin
			ram_adr   <= ram.adr;
			ram_dat_w <= ram.wdat;
		end
		if (finish) begin
			ram.rdat <= ram_dat_r;
		end
	end

	// Classic cycle carries the request the core still holds, address unchanged
	stb_matches_request: assert property (@(posedge clk_sys) disable iff (reset)
		ram_stb |-> ram.valid && ram_adr == ram.adr);

endmodule

// File: hdl/zx_pager.sv
// ZX Spectrum memory pager top level.
// CPU Wishbone slave in, flat RAM Wishbone master out, machine type from a pin.

module zx_pager (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  zx_pager_pkg::machine_e             machine,

	// CPU side
	input  logic                               cpu_cyc,
	input  logic                               cpu_stb,
	input  logic                               cpu_we,
	input  logic                               cpu_io,     // Address tag for port cycles
	input  logic [zx_pager_pkg::cpu_adr_w-1:0] cpu_adr,
	input  logic [zx_pager_pkg::data_w-1:0]    cpu_dat_w,
	output logic [zx_pager_pkg::data_w-1:0]    cpu_dat_r,
	output logic                               cpu_ack,

	// RAM side
	output logic                               ram_cyc,
	output logic                               ram_stb,
	output logic                               ram_we,
	output logic [zx_pager_pkg::ram_adr_w-1:0] ram_adr,
	output logic [zx_pager_pkg::data_w-1:0]    ram_dat_w,
	input  logic [zx_pager_pkg::data_w-1:0]    ram_dat_r,
	input  logic                               ram_ack
);

	cpu_req_if cpu_req ();
	ram_req_if ram_req ();

	wb_cpu_slave wb_cpu_slave_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_cyc   (cpu_cyc),
		.cpu_stb   (cpu_stb),
		.cpu_we    (cpu_we),
		.cpu_io    (cpu_io),
		.cpu_adr   (cpu_adr),
		.cpu_dat_w (cpu_dat_w),
		.cpu_dat_r (cpu_dat_r),
		.cpu_ack   (cpu_ack),
		.req       (cpu_req.requester)
	);

	pager_core pager_core_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.machine (machine),
		.req     (cpu_req.responder),
		.ram     (ram_req.requester)
	);

	ram_master ram_master_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ram       (ram_req.responder),
		.ram_cyc   (ram_cyc),
		.ram_stb   (ram_stb),
		.ram_we    (ram_we),
		.ram_adr   (ram_adr),
		.ram_dat_w (ram_dat_w),
		.ram_dat_r (ram_dat_r),
		.ram_ack   (ram_ack)
	);

endmodule

// File: tests/tb_clock.sv
// Clock and reset source for the pager testbench.
// A pulse on restart, seen at a rising edge, starts a new 4 cycle reset.

module tb_clock (
	input  logic restart,
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned hold = 3;  // Cycles left after the current one
	logic        restart_seen;

	initial begin
		clk_sys = 1'b0;
		reset   = 1'b1;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		restart_seen = restart;
		#10;
		if (restart_seen) begin
			reset = 1'b1;
			hold  = 3;
		end else if (hold != 0) begin
			hold--;
		end else begin
			reset = 1'b0;
		end
	end

endmodule

// File: tests/tb_zx_pager.sv
// Testbench for the ZX Spectrum pager. Drives CPU cycles, models the flat RAM
// with random wait states and checks every RAM strobe and CPU read result.

module tb_zx_pager;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned seg_size  = 1 << zx_pager_pkg::seg_w;
	localparam logic [7:0]  port_fill = 8'hFF;
	// About 12 cycles per access at most, plus seven resets
	localparam int unsigned max_accesses = 320;
	localparam int unsigned watchdog_ns  = (max_accesses * 12 + 7 * 8) * 100;
	// +3 all RAM layouts, banks for segments 0 to 3
	localparam int unsigned layout [4][4] = '{'{0, 1, 2, 3}, '{4, 5, 6, 7},
		'{4, 5, 6, 3}, '{4, 7, 6, 3}};

	logic clk_sys, reset, restart;
	zx_pager_pkg::machine_e machine;
	logic cpu_cyc, cpu_stb, cpu_we, cpu_io, cpu_ack;
	logic [zx_pager_pkg::cpu_adr_w-1:0] cpu_adr;
	logic [zx_pager_pkg::data_w-1:0] cpu_dat_w, cpu_dat_r, ram_dat_w;
	logic [zx_pager_pkg::data_w-1:0] ram_dat_r = '0;
	logic ram_cyc, ram_stb, ram_we;
	logic ram_ack = 1'b0;
	logic [zx_pager_pkg::ram_adr_w-1:0] ram_adr;

	logic [7:0] mem [0:(1 << zx_pager_pkg::ram_adr_w)-1];  // Flat RAM and ROM images
	int seed = 76514;
	int unsigned waits;
	logic busy, stb_seen, ack_seen;

	// Mirror of the paging registers and the expectation for the current cycle
	zx_pager_pkg::machine_e mode;
	logic [7:0] mirror_7ffd, mirror_1ffd;
	logic [zx_pager_pkg::ram_adr_w-1:0] exp_adr;
	logic exp_stb, exp_we, ack_pending;
	logic [7:0] exp_wdat, exp_rdat;

	tb_clock tb_clock_inst (.restart(restart), .clk_sys(clk_sys), .reset(reset));

	zx_pager zx_pager_inst (.*);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] want);
		stop_run($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
			$time, name, got, want));
	endtask

	// ========================================================================
	// Reference model
	// ========================================================================
	// Returns the blocked flag above the flat address
	function automatic logic [zx_pager_pkg::ram_adr_w:0] expected_map(
		input logic [zx_pager_pkg::cpu_adr_w-1:0] adr, input logic we);
		logic [1:0]  seg;
		logic [31:0] rom;
		logic [31:0] bank;
		logic [31:0] flat;
		seg = adr[15:14];
		if (mode == zx_pager_pkg::m_plus3 && mirror_1ffd[0]) begin
			flat = layout[mirror_1ffd[2:1]][seg] * seg_size + adr % seg_size;
			return {1'b0, flat[zx_pager_pkg::ram_adr_w-1:0]};
		end
		if (seg == 2'd0) begin
			case (mode)
				zx_pager_pkg::m_zx48:  rom = 1;
				zx_pager_pkg::m_zx128: rom = mirror_7ffd[4] ? 1 : 0;
				default:               rom = (mirror_1ffd[2] ? 2 : 0) + (mirror_7ffd[4] ? 1 : 0);
			endcase
			flat = zx_pager_pkg::rom_base + rom * seg_size + adr % seg_size;
			return {we, flat[zx_pager_pkg::ram_adr_w-1:0]};  // ROM writes blocked
		end
		if (seg == 2'd1)
			bank = 5;
		else if (seg == 2'd2)
			bank = 2;
		else
			bank = (mode == zx_pager_pkg::m_zx48) ? 0 : 32'(mirror_7ffd[2:0]);
		flat = bank * seg_size + adr % seg_size;
		return {1'b0, flat[zx_pager_pkg::ram_adr_w-1:0]};
	endfunction

	// Port write decode as the paging registers see it
	function automatic void update_mirror(input logic [15:0] adr, input logic [7:0] dat);
		logic plus3;
		logic enabled;
		plus3   = (mode == zx_pager_pkg::m_plus3);
		enabled = (mode != zx_pager_pkg::m_zx48) && !mirror_7ffd[5];
		if (enabled && !adr[15] && !adr[1] && (adr[14] || !plus3))
			mirror_7ffd = dat;
		else if (plus3 && enabled && adr[15:12] == 4'h1 && !adr[1])
			mirror_1ffd = dat;
	endfunction

	function automatic logic [15:0] random_in_seg(input logic [1:0] seg);
		logic [31:0] rnd;
		rnd = $random(seed);
		return {seg, rnd[13:0]};
	endfunction

	// ========================================================================
	// Stimulus tasks
	// ========================================================================
	task automatic restart_dut(input zx_pager_pkg::machine_e m);
		machine     = m;
		mode        = m;
		mirror_7ffd = '0;
		mirror_1ffd = '0;
		restart     = 1'b1;
		@(posedge clk_sys);
		#10;
		restart = 1'b0;
		do @(posedge clk_sys); while (reset);
		#10;
	endtask

	task automatic cpu_cycle(input logic io, input logic we, input logic [15:0] adr,
		input logic [7:0] wdat, output logic [7:0] rdat);
		logic [zx_pager_pkg::ram_adr_w:0] map;
		int unsigned waited;
		map         = expected_map(adr, we);
		exp_adr     = map[zx_pager_pkg::ram_adr_w-1:0];
		exp_stb     = !io && !map[zx_pager_pkg::ram_adr_w];
		exp_we      = we;
		exp_wdat    = wdat;
		exp_rdat    = io ? port_fill : mem[exp_adr];
		ack_pending = 1'b1;
		if (io && we)
			update_mirror(adr, wdat);
		cpu_cyc   = 1'b1;
		cpu_stb   = 1'b1;
		cpu_io    = io;
		cpu_we    = we;
		cpu_adr   = adr;
		cpu_dat_w = wdat;
		waited    = 0;
		do begin
			@(posedge clk_sys);
			waited++;
		end while (!cpu_ack && waited < 20);
		if (!cpu_ack) begin
			stop_run("CPU cycle got no acknowledge within 20 clock cycles");
		end else begin
			rdat = cpu_dat_r;
			#10;
			cpu_cyc = 1'b0;
			cpu_stb = 1'b0;
		end
	endtask

	// RAM slave, 0 to 3 wait states per cycle
	always @(posedge clk_sys) begin
		stb_seen = ram_cyc && ram_stb;
		ack_seen = ram_ack;
		#10;
		if (ack_seen) begin
			ram_ack = 1'b0;
			busy    = 1'b0;
		end else if (stb_seen) begin
			if (!busy) begin
				busy  = 1'b1;
				waits = $random(seed) & 3;
			end
			if (waits == 0) begin
				ram_ack = 1'b1;
				if (ram_we)
					mem[ram_adr] = ram_dat_w;
				else
					ram_dat_r = mem[ram_adr];
			end else begin
				waits--;
			end
		end
	end

	// Compare DUT outputs with the expectation
	always @(posedge clk_sys) begin
		if (!reset && ram_stb) begin
			assert (exp_stb) else stop_run($sformatf("Unexpected RAM strobe at %0d ns", $time));
			assert (ram_cyc) else value_error("ram_cyc", 32'(ram_cyc), 32'(1'b1));
			assert (ram_adr == exp_adr) else value_error("ram_adr", 32'(ram_adr), 32'(exp_adr));
			assert (ram_we == exp_we) else value_error("ram_we", 32'(ram_we), 32'(exp_we));
			assert (!exp_we || ram_dat_w == exp_wdat)
				else value_error("ram_dat_w", 32'(ram_dat_w), 32'(exp_wdat));
		end
		if (!reset && cpu_ack) begin
			assert (ack_pending) else stop_run("cpu_ack came without a pending CPU cycle");
			assert (!ram_cyc) else value_error("ram_cyc", 32'(ram_cyc), 32'(1'b0));
			assert (exp_we || cpu_dat_r == exp_rdat)
				else value_error("cpu_dat_r", 32'(cpu_dat_r), 32'(exp_rdat));
			ack_pending = 1'b0;
		end
	end

	initial begin
		#(watchdog_ns);
		stop_run("Timeout: the tests did not finish in the expected time");
	end

	initial begin
		logic [7:0]  dat;
		logic [7:0]  old;
		logic [15:0] adr;
		logic [31:0] rnd;
		restart   = 1'b0;
		machine   = zx_pager_pkg::m_zx128;
		cpu_cyc   = 1'b0;
		cpu_stb   = 1'b0;
		cpu_we    = 1'b0;
		cpu_io    = 1'b0;
		cpu_adr   = '0;
		cpu_dat_w = '0;
		busy      = 1'b0;
		for (logic [18:0] a = 0; a < 19'h40000; a++) begin
			rnd = $random(seed);
			if (a < zx_pager_pkg::rom_base)
				mem[a[17:0]] = a[7:0] ^ a[15:8] ^ {3'b000, a[17:13]};
			else if (a < zx_pager_pkg::rom_base + zx_pager_pkg::rom_count * seg_size)
				mem[a[17:0]] = rnd[7:0];  // ROM images
		end

		// 128K reset layout, then write and read back in segments 1 to 3
		restart_dut(zx_pager_pkg::m_zx128);
		for (int i = 0; i < 32; i++)
			cpu_cycle(1'b0, 1'b0, random_in_seg(2'(i % 4)), '0, dat);
		for (int i = 0; i < 18; i++) begin
			adr = random_in_seg(2'(1 + i % 3));
			rnd = $random(seed);
			cpu_cycle(1'b0, 1'b1, adr, rnd[7:0], dat);
			cpu_cycle(1'b0, 1'b0, adr, '0, dat);
			assert (dat == rnd[7:0]) else value_error("cpu_dat_r", 32'(dat), 32'(rnd[7:0]));
		end

		// Random 7FFD values on partially decoded addresses, lock bit clear
		restart_dut(zx_pager_pkg::m_zx128);
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			cpu_cycle(1'b1, 1'b1, rnd[15:0] & 16'h7FFD, rnd[23:16] & 8'hDF, dat);
			cpu_cycle(1'b0, 1'b0, random_in_seg(2'd3), '0, dat);
			cpu_cycle(1'b0, 1'b0, random_in_seg(2'd0), '0, dat);
			cpu_cycle(1'b1, 1'b0, rnd[31:16], '0, dat);
		end

		// Lock bit freezes both ports until the next reset
		restart_dut(zx_pager_pkg::m_zx128);
		cpu_cycle(1'b1, 1'b1, 16'h7FFD, 8'h23, dat);
		cpu_cycle(1'b1, 1'b1, 16'h7FFD, 8'h16, dat);
		for (int i = 0; i < 4; i++)
			cpu_cycle(1'b0, 1'b0, random_in_seg(2'(i)), '0, dat);
		restart_dut(zx_pager_pkg::m_plus3);
		cpu_cycle(1'b1, 1'b1, 16'h7FFD, 8'h31, dat);
		cpu_cycle(1'b1, 1'b1, 16'h1FFD, 8'h07, dat);
		cpu_cycle(1'b1, 1'b1, 16'h7FFD, 8'h06, dat);
		for (int i = 0; i < 4; i++)
			cpu_cycle(1'b0, 1'b0, random_in_seg(2'(i)), '0, dat);
		restart_dut(zx_pager_pkg::m_zx128);
		cpu_cycle(1'b1, 1'b1, 16'h7FFD, 8'h04, dat);
		cpu_cycle(1'b0, 1'b0, random_in_seg(2'd3), '0, dat);

		// ROM writes are acknowledged without touching RAM
		for (int i = 0; i < 4; i++) begin
			adr = random_in_seg(2'd0);
			cpu_cycle(1'b0, 1'b0, adr, '0, old);
			cpu_cycle(1'b0, 1'b1, adr, ~old, dat);
			cpu_cycle(1'b0, 1'b0, adr, '0, dat);
			assert (dat == old) else value_error("cpu_dat_r", 32'(dat), 32'(old));
		end

		// +3 special layouts, then normal ROM selection from both ports
		restart_dut(zx_pager_pkg::m_plus3);
		for (int l = 0; l < 4; l++) begin
			cpu_cycle(1'b1, 1'b1, 16'h1FFD, {5'b00000, 2'(l), 1'b1}, dat);
			for (int s = 0; s < 4; s++)
				cpu_cycle(1'b0, 1'b0, random_in_seg(2'(s)), '0, dat);
			adr = random_in_seg(2'd0);
			rnd = $random(seed);
			cpu_cycle(1'b0, 1'b1, adr, rnd[7:0], dat);
			cpu_cycle(1'b0, 1'b0, adr, '0, dat);
			assert (dat == rnd[7:0]) else value_error("cpu_dat_r", 32'(dat), 32'(rnd[7:0]));
		end
		for (int r = 0; r < 4; r++) begin
			cpu_cycle(1'b1, 1'b1, 16'h1FFD, {5'b00000, r[1], 2'b00}, dat);
			cpu_cycle(1'b1, 1'b1, 16'h7FFD, {3'b000, r[0], 4'h0}, dat);
			cpu_cycle(1'b0, 1'b0, random_in_seg(2'd0), '0, dat);
			cpu_cycle(1'b0, 1'b0, random_in_seg(2'd0), '0, dat);
		end

		// 48K ignores both ports
		restart_dut(zx_pager_pkg::m_zx48);
		cpu_cycle(1'b1, 1'b1, 16'h7FFD, 8'h07, dat);
		cpu_cycle(1'b1, 1'b1, 16'h1FFD, 8'h05, dat);
		for (int i = 0; i < 8; i++)
			cpu_cycle(1'b0, 1'b0, random_in_seg(2'(3 * (i % 2))), '0, dat);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: tb.f
hdl/zx_pager_pkg.sv
hdl/cpu_req_if.sv
hdl/ram_req_if.sv
hdl/wb_cpu_slave.sv
hdl/page_latch.sv
hdl/bank_mapper.sv
hdl/pager_core.sv
hdl/ram_master.sv
hdl/zx_pager.sv
tests/tb_clock.sv
tests/tb_zx_pager.sv

// File: Makefile
# Verilator build and run of the pager testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --timescale 1ns/100ps -f tb.f \
		--top-module tb_zx_pager -Mdir obj_dir -o tb_zx_pager
	@out=$$(./obj_dir/tb_zx_pager 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
